/* src/cpu_pkg.sv */
package cpu_pkg;

    // ====================
    // Widths and constants
    // ====================
    localparam int DATA_WIDTH     = 8;
    localparam int ADDR_WIDTH     = 16;
    localparam int MAX_MICROSTEPS = 8;

    localparam logic [ADDR_WIDTH-1:0] RESET_VECTOR = 16'h0000; // First fetch address

    typedef logic [$clog2(MAX_MICROSTEPS)-1:0] microstep_t;

    // ====================
    // Encodings
    // ====================
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        HLT    = 8'h01,
        LDI_A  = 8'h10,
        LDI_B  = 8'h11,
        LDI_C  = 8'h12,
        MOV_AB = 8'h20, // A to B
        MOV_BA = 8'h21,
        MOV_AC = 8'h22,
        MOV_CA = 8'h23,
        ADD_B  = 8'h30,
        ADD_C  = 8'h31,
        SUB_B  = 8'h32,
        SUB_C  = 8'h33,
        CMP_B  = 8'h34,
        INR_A  = 8'h35,
        DCR_A  = 8'h36,
        ANI    = 8'h40,
        ORI    = 8'h41,
        XRI    = 8'h42,
        SEC    = 8'h50,
        CLC    = 8'h51,
        JMP    = 8'h60,
        JZ     = 8'h61,
        JNZ    = 8'h62,
        JC     = 8'h63,
        JNC    = 8'h64,
        LDA    = 8'h70,
        STA    = 8'h71
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_INR,
        ALU_DCR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_UNDEF
    } alu_op_t;

    typedef enum logic [2:0] {
        S_RESET,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } state_t;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
    } status_t;

    typedef struct packed {
        logic    mem_read;
        logic    mem_write;
        logic    oe_a;
        logic    oe_b;
        logic    oe_c;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    oe_alu;
        logic    oe_mdr;
        logic    load_a;
        logic    load_b;
        logic    load_c;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    load_status;
        logic    load_sets_zn;   // Z and N from dbus, carry kept
        logic    alu_src2_c;
        logic    alu_src2_temp1;
        logic    set_carry;
        logic    clear_carry;
        logic    load_mar_pc;
        logic    load_mar_low;
        logic    load_mar_high;
        logic    pc_enable;
        logic    load_pc_low;
        logic    load_pc_high;
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_not_carry;
        logic    last_step;
        logic    halt;
        alu_op_t alu_op;
    } control_word_t;

    // Wishbone classic
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [ADDR_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] dat_r;
        logic                  ack;
    } wb_rsp_t;

    // Operand bytes that follow the opcode
    function automatic logic [1:0] operand_bytes(input opcode_t op);
        case (op)
            LDI_A, LDI_B, LDI_C, ANI, ORI, XRI: return 2'd1;
            JMP, JZ, JNZ, JC, JNC, LDA, STA:     return 2'd2;
            default:                             return 2'd0;
        endcase
    endfunction

endpackage

/* src/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  STATIC_RESET,
    input  logic [DATA_WIDTH-1:0] dbus,
    input  status_t               status,
    input  logic                  bus_done,
    output control_word_t         ctrl,
    output logic                  halted
);

    // ====================
    // Microcode ROM
    // ====================
    function automatic control_word_t rom_word(input opcode_t op, input microstep_t ms);
        control_word_t cw;
        cw = '0;
        cw.alu_op = ALU_UNDEF;
        case (op)
            NOP: cw.last_step = 1'b1;
            HLT: cw.halt = 1'b1;
            LDI_A, LDI_B, LDI_C: begin
                cw.oe_temp_1    = 1'b1;
                cw.load_a       = (op == LDI_A);
                cw.load_b       = (op == LDI_B);
                cw.load_c       = (op == LDI_C);
                cw.load_status  = 1'b1;
                cw.load_sets_zn = 1'b1;
                cw.last_step    = 1'b1;
            end
            MOV_AB, MOV_AC, MOV_BA, MOV_CA: begin
                cw.oe_a      = (op == MOV_AB) || (op == MOV_AC);
                cw.oe_b      = (op == MOV_BA);
                cw.oe_c      = (op == MOV_CA);
                cw.load_a    = (op == MOV_BA) || (op == MOV_CA);
                cw.load_b    = (op == MOV_AB);
                cw.load_c    = (op == MOV_AC);
                cw.last_step = 1'b1;
            end
            ADD_B, ADD_C, SUB_B, SUB_C, CMP_B, INR_A, DCR_A, ANI, ORI, XRI: begin
                // Operand select stays up on both steps
                cw.alu_src2_c     = (op == ADD_C) || (op == SUB_C);
                cw.alu_src2_temp1 = (op == ANI) || (op == ORI) || (op == XRI);
                if (ms == 3'd0) begin
                    case (op)
                        ADD_B, ADD_C:        cw.alu_op = ALU_ADD;
                        SUB_B, SUB_C, CMP_B: cw.alu_op = ALU_SUB;
                        INR_A:               cw.alu_op = ALU_INR;
                        DCR_A:               cw.alu_op = ALU_DCR;
                        ANI:                 cw.alu_op = ALU_AND;
                        ORI:                 cw.alu_op = ALU_OR;
                        default:             cw.alu_op = ALU_XOR;
                    endcase
                end else begin
                    cw.oe_alu      = (op != CMP_B); // Compare touches flags only
                    cw.load_a      = (op != CMP_B);
                    cw.load_status = 1'b1;
                    cw.last_step   = 1'b1;
                end
            end
            SEC, CLC: begin
                cw.set_carry   = (op == SEC);
                cw.clear_carry = (op == CLC);
                cw.load_status = 1'b1;
                cw.last_step   = 1'b1;
            end
            JMP, JZ, JNZ, JC, JNC: begin
                if (ms == 3'd0) begin
                    cw.oe_temp_1       = 1'b1;
                    cw.load_pc_low     = 1'b1;
                    cw.check_zero      = (op == JZ);
                    cw.check_not_zero  = (op == JNZ);
                    cw.check_carry     = (op == JC);
                    cw.check_not_carry = (op == JNC);
                end else begin
                    cw.oe_temp_2    = 1'b1;
                    cw.load_pc_high = 1'b1;
                    cw.last_step    = 1'b1;
                end
            end
            LDA, STA: begin
                case (ms)
                    3'd0: begin
                        cw.oe_temp_1    = 1'b1;
                        cw.load_mar_low = 1'b1;
                    end
                    3'd1: begin
                        cw.oe_temp_2     = 1'b1;
                        cw.load_mar_high = 1'b1;
                    end
                    default: begin
                        cw.mem_read     = (op == LDA);
                        cw.oe_mdr       = (op == LDA);
                        cw.load_a       = (op == LDA);
                        cw.load_status  = (op == LDA);
                        cw.load_sets_zn = (op == LDA);
                        cw.mem_write    = (op == STA);
                        cw.oe_a         = (op == STA);
                        cw.last_step    = 1'b1;
                    end
                endcase
            end
            default: cw.halt = 1'b1; // Unknown opcode stops the core
        endcase
        return cw;
    endfunction

    // ====================
    // State
    // ====================
    state_t        state, state_next;
    microstep_t    step, step_next;
    logic [1:0]    byte_cnt, byte_cnt_next;
    opcode_t       opcode;          // IR
    alu_op_t       alu_op_q;
    control_word_t rom_cw;
    logic          check_any;
    logic          check_pass;
    logic          bus_wait;

    always_ff @(posedge clk) begin
        if (STATIC_RESET) begin
            state    <= S_RESET;
            step     <= '0;
            byte_cnt <= '0;
            alu_op_q <= ALU_UNDEF;
        end else begin
            state    <= state_next;
            step     <= step_next;
            byte_cnt <= byte_cnt_next;
            if (state == S_EXECUTE && step == 3'd0)
                alu_op_q <= rom_cw.alu_op; // Held for the rest of the instruction
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir)
            opcode <= opcode_t'(dbus);
    end

    assign rom_cw    = rom_word(opcode, step);
    assign check_any = rom_cw.check_zero || rom_cw.check_not_zero ||
                       rom_cw.check_carry || rom_cw.check_not_carry;
    assign check_pass = (rom_cw.check_zero && status.zero) ||
                        (rom_cw.check_not_zero && !status.zero) ||
                        (rom_cw.check_carry && status.carry) ||
                        (rom_cw.check_not_carry && !status.carry);
    assign bus_wait  = (rom_cw.mem_read || rom_cw.mem_write) && !bus_done;

    // ====================
    // Next state and control word
    // ====================
    always_comb begin
        state_next    = state;
        step_next     = step;
        byte_cnt_next = byte_cnt;
        ctrl          = '0;
        ctrl.alu_op   = ALU_UNDEF;
        case (state)
            S_RESET: state_next = S_LATCH_ADDR;
            S_LATCH_ADDR: begin
                ctrl.load_mar_pc = 1'b1;
                state_next       = S_READ_BYTE;
            end
            S_READ_BYTE: begin
                ctrl.mem_read = 1'b1;
                ctrl.oe_mdr   = 1'b1;
                if (bus_done) begin // Byte lands on the ack edge
                    ctrl.pc_enable   = 1'b1;
                    ctrl.load_ir     = (byte_cnt == 2'd0);
                    ctrl.load_temp_1 = (byte_cnt == 2'd1);
                    ctrl.load_temp_2 = (byte_cnt == 2'd2);
                    byte_cnt_next    = byte_cnt + 2'd1;
                    state_next       = S_CHK_MORE_BYTES;
                end
            end
            S_CHK_MORE_BYTES: begin
                if (byte_cnt > operand_bytes(opcode)) begin
                    state_next    = S_EXECUTE;
                    byte_cnt_next = '0;
                end else begin
                    state_next = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                ctrl = rom_cw;
                if (step != 3'd0)
                    ctrl.alu_op = alu_op_q;
                if (bus_wait) begin
                    // Memory steps only load A and flags
                    ctrl.load_a      = 1'b0;
                    ctrl.load_status = 1'b0;
                end else if (ctrl.halt) begin
                    state_next = S_HALT;
                    step_next  = '0;
                end else if (check_any && !check_pass) begin
                    ctrl.load_pc_low  = 1'b0; // Branch not taken
                    ctrl.load_pc_high = 1'b0;
                    state_next        = S_LATCH_ADDR;
                    step_next         = '0;
                end else if (ctrl.last_step) begin
                    state_next = S_LATCH_ADDR;
                    step_next  = '0;
                end else begin
                    step_next = step + 3'd1;
                end
            end
            default: ; // S_HALT holds until reset
        endcase
    end

    assign halted = (state == S_HALT);

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  STATIC_RESET,
    input  control_word_t         ctrl,
    input  logic [DATA_WIDTH-1:0] alu_result,
    input  logic [DATA_WIDTH-1:0] rdata,
    output logic [DATA_WIDTH-1:0] dbus,
    output logic [DATA_WIDTH-1:0] a,
    output logic [DATA_WIDTH-1:0] operand
);

    logic [DATA_WIDTH-1:0] reg_b, reg_c;
    logic [DATA_WIDTH-1:0] temp_1, temp_2;

    always_ff @(posedge clk) begin
        if (STATIC_RESET) begin
            a     <= '0;
            reg_b <= '0;
            reg_c <= '0;
        end else begin
            if (ctrl.load_a) a <= dbus;
            if (ctrl.load_b) reg_b <= dbus;
            if (ctrl.load_c) reg_c <= dbus;
        end
    end

    // Operand bytes from fetch
    always_ff @(posedge clk) begin
        if (ctrl.load_temp_1) temp_1 <= dbus;
        if (ctrl.load_temp_2) temp_2 <= dbus;
    end

    // Internal bus, one source at a time
    always_comb begin
        if (ctrl.oe_a)           dbus = a;
        else if (ctrl.oe_b)      dbus = reg_b;
        else if (ctrl.oe_c)      dbus = reg_c;
        else if (ctrl.oe_temp_1) dbus = temp_1;
        else if (ctrl.oe_temp_2) dbus = temp_2;
        else if (ctrl.oe_alu)    dbus = alu_result;
        else if (ctrl.oe_mdr)    dbus = rdata;
        else                     dbus = '0;
    end

    assign operand = ctrl.alu_src2_temp1 ? temp_1 :
                     ctrl.alu_src2_c     ? reg_c  : reg_b;

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  STATIC_RESET,
    input  control_word_t         ctrl,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] operand,
    input  logic [DATA_WIDTH-1:0] dbus,
    output logic [DATA_WIDTH-1:0] alu_result,
    output status_t               status
);

    logic [DATA_WIDTH:0] wide; // Top bit is carry or borrow

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: wide = {1'b0, a} + {1'b0, operand};
            ALU_SUB: wide = {1'b0, a} - {1'b0, operand};
            ALU_INR: wide = {1'b0, a} + 1'b1;
            ALU_DCR: wide = {1'b0, a} - 1'b1;
            ALU_AND: wide = {1'b0, a & operand};
            ALU_OR:  wide = {1'b0, a | operand};
            ALU_XOR: wide = {1'b0, a ^ operand};
            default: wide = {1'b0, a}; // PASS and UNDEF
        endcase
    end

    assign alu_result = wide[DATA_WIDTH-1:0];

    // ====================
    // Status flags
    // ====================
    always_ff @(posedge clk) begin
        if (STATIC_RESET) begin
            status <= '0;
        end else if (ctrl.load_status) begin
            if (ctrl.set_carry || ctrl.clear_carry) begin
                status.carry <= ctrl.set_carry; // SEC and CLC
            end else if (ctrl.load_sets_zn) begin
                status.zero     <= (dbus == '0);
                status.negative <= dbus[DATA_WIDTH-1];
            end else begin
                status.zero     <= (alu_result == '0);
                status.negative <= alu_result[DATA_WIDTH-1];
                case (ctrl.alu_op)
                    ALU_ADD, ALU_SUB:         status.carry <= wide[DATA_WIDTH];
                    ALU_AND, ALU_OR, ALU_XOR: status.carry <= 1'b0;
                    default: ; // INR and DCR keep carry
                endcase
            end
        end
    end

endmodule

/* src/address_unit.sv */
`timescale 1ns/1ps

module address_unit import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  STATIC_RESET,
    input  control_word_t         ctrl,
    input  logic [DATA_WIDTH-1:0] dbus,
    output logic [ADDR_WIDTH-1:0] adr
);

    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] mar;

    // Program counter
    always_ff @(posedge clk) begin
        if (STATIC_RESET) begin
            pc <= RESET_VECTOR;
        end else begin
            if (ctrl.pc_enable)
                pc <= pc + 1'b1;
            if (ctrl.load_pc_low)
                pc[DATA_WIDTH-1:0] <= dbus;
            if (ctrl.load_pc_high)
                pc[ADDR_WIDTH-1:DATA_WIDTH] <= dbus;
        end
    end

    // MAR from PC or from operand bytes
    always_ff @(posedge clk) begin
        if (ctrl.load_mar_pc)
            mar <= pc;
        if (ctrl.load_mar_low)
            mar[DATA_WIDTH-1:0] <= dbus;
        if (ctrl.load_mar_high)
            mar[ADDR_WIDTH-1:DATA_WIDTH] <= dbus;
    end

    assign adr = mar;

endmodule

/* src/wb_master.sv */
`timescale 1ns/1ps

module wb_master import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  STATIC_RESET,
    input  control_word_t         ctrl,
    input  logic [ADDR_WIDTH-1:0] adr,
    input  logic [DATA_WIDTH-1:0] dbus,
    input  wb_rsp_t               bus_in,
    output wb_req_t               bus_out,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  bus_done
);

    logic                  cyc_q, we_q;
    logic                  cool; // Idle cycle after each ack
    logic                  start;
    logic [ADDR_WIDTH-1:0] adr_q;
    logic [DATA_WIDTH-1:0] dat_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    assign start    = !cyc_q && !cool && (ctrl.mem_read || ctrl.mem_write);
    assign bus_done = cyc_q && bus_in.ack;

    always_ff @(posedge clk) begin
        if (STATIC_RESET) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
            cool  <= 1'b0;
        end else begin
            cool <= bus_done;
            if (bus_done) begin
                cyc_q <= 1'b0;
                we_q  <= 1'b0;
            end else if (start) begin
                cyc_q <= 1'b1;
                we_q  <= ctrl.mem_write;
            end
        end
    end

    // Request payload held until ack
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= adr;
            dat_q <= dbus;
        end
        if (bus_done)
            rdata_q <= bus_in.dat_r;
    end

    // Read data is passed straight through on the ack cycle
    assign rdata   = bus_done ? bus_in.dat_r : rdata_q;
    assign bus_out = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat_w: dat_q};

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic    clk,
    input  logic    STATIC_RESET,
    input  wb_rsp_t bus_in,
    output wb_req_t bus_out,
    output logic    halted
);

    // ====================
    // Internal wiring
    // ====================
    control_word_t         ctrl;
    status_t               status;
    logic [DATA_WIDTH-1:0] dbus;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] operand;
    logic [DATA_WIDTH-1:0] alu_result;
    logic [DATA_WIDTH-1:0] rdata;
    logic [ADDR_WIDTH-1:0] adr;
    logic                  bus_done;

    cpu_control cpu_control_inst (
        .clk          (clk),
        .STATIC_RESET (STATIC_RESET),
        .dbus         (dbus),
        .status       (status),
        .bus_done     (bus_done),
        .ctrl         (ctrl),
        .halted       (halted)
    );

    register_file register_file_inst (
        .clk          (clk),
        .STATIC_RESET (STATIC_RESET),
        .ctrl         (ctrl),
        .alu_result   (alu_result),
        .rdata        (rdata),
        .dbus         (dbus),
        .a            (a),
        .operand      (operand)
    );

    alu alu_inst (
        .clk          (clk),
        .STATIC_RESET (STATIC_RESET),
        .ctrl         (ctrl),
        .a            (a),
        .operand      (operand),
        .dbus         (dbus),
        .alu_result   (alu_result),
        .status       (status)
    );

    address_unit address_unit_inst (
        .clk          (clk),
        .STATIC_RESET (STATIC_RESET),
        .ctrl         (ctrl),
        .dbus         (dbus),
        .adr          (adr)
    );

    wb_master wb_master_inst (
        .clk          (clk),
        .STATIC_RESET (STATIC_RESET),
        .ctrl         (ctrl),
        .adr          (adr),
        .dbus         (dbus),
        .bus_in       (bus_in),
        .bus_out      (bus_out),
        .rdata        (rdata),
        .bus_done     (bus_done)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

/* testbench/cpu_top_asserts.sv */
`timescale 1ns/1ps

module cpu_top_asserts import cpu_pkg::*; (
    input logic    clk,
    input logic    STATIC_RESET,
    input wb_rsp_t bus_in,
    input wb_req_t bus_out,
    input logic    halted
);

    int fail_count = 0; // Failed assertions so far

    // ====================
    // Wishbone classic
    // ====================
    a_stb_needs_cyc: assert property (@(posedge clk) disable iff (STATIC_RESET)
        bus_out.stb |-> bus_out.cyc)
        else begin
            fail_count++;
            $error("stb is high while cyc is low");
        end

    // Request held until ack
    a_request_stable: assert property (@(posedge clk) disable iff (STATIC_RESET)
        (bus_out.stb && !bus_in.ack) |=> bus_out.stb && $stable(bus_out.adr) &&
                                         $stable(bus_out.we) && $stable(bus_out.dat_w))
        else begin
            fail_count++;
            $error("Request changed before ack");
        end

    a_idle_when_halted: assert property (@(posedge clk) disable iff (STATIC_RESET)
        halted |-> !bus_out.cyc)
        else begin
            fail_count++;
            $error("Bus cycle while halted");
        end

    a_idle_in_reset: assert property (@(posedge clk) STATIC_RESET |=> !bus_out.cyc)
        else begin
            fail_count++;
            $error("cyc is high during reset");
        end

endmodule

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    logic    clk;
    logic    STATIC_RESET = 1'b1;
    wb_rsp_t bus_in = '0;
    wb_req_t bus_out;
    logic    halted;

    logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1]; // Code, data and model memory
    logic [31:0]           lcg_state = 32'h0f27_3dd6;
    int                    wait_cnt;

    // Expected bus accesses of the current instruction
    logic [ADDR_WIDTH-1:0] exp_adr [$];
    logic                  exp_we [$];
    logic [DATA_WIDTH-1:0] exp_dat [$];

    // Instruction model state
    logic [DATA_WIDTH-1:0] model_a, model_b, model_c;
    logic                  model_z, model_cy;
    logic [ADDR_WIDTH-1:0] model_pc;
    logic                  model_halted;

    opcode_t op_table [27] = '{NOP, LDI_A, LDI_B, LDI_C, MOV_AB, MOV_BA, MOV_AC, MOV_CA,
                               ADD_B, ADD_C, SUB_B, SUB_C, CMP_B, INR_A, DCR_A, ANI, ORI,
                               XRI, SEC, CLC, JMP, JZ, JNZ, JC, JNC, LDA, STA};

    // Stores A, B and C at 9000h..9002h, then stops
    logic [DATA_WIDTH-1:0] epilogue [12] = '{STA, 8'h00, 8'h90, MOV_BA, STA, 8'h01, 8'h90,
                                             MOV_CA, STA, 8'h02, 8'h90, HLT};

    tb_clock tb_clock_inst (.clk(clk));

    cpu_top cpu_top_inst (
        .clk          (clk),
        .STATIC_RESET (STATIC_RESET),
        .bus_in       (bus_in),
        .bus_out      (bus_out),
        .halted       (halted)
    );

    bind cpu_top cpu_top_asserts asserts_inst (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8; // Low bits of an LCG are weak
    endfunction

    task automatic report_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_mismatch(string name, logic [15:0] expected, logic [15:0] actual);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        report_failure();
    endtask

    task automatic push_access(logic [ADDR_WIDTH-1:0] adr, logic we, logic [DATA_WIDTH-1:0] dat);
        exp_adr.push_back(adr);
        exp_we.push_back(we);
        exp_dat.push_back(dat);
    endtask

    // ====================
    // Program generator
    // ====================
    task automatic build_program();
        logic [ADDR_WIDTH-1:0] pc;
        logic [ADDR_WIDTH-1:0] target;
        opcode_t               op;
        int                    pad;
        for (int i = 0; i < (1 << ADDR_WIDTH); i++)
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;
        pc = RESET_VECTOR;
        for (int n = 0; n < 40; n++) begin
            op = op_table[next_rand() % 27];
            mem[pc] = op;
            pc++;
            if (op == LDA || op == STA) begin
                mem[pc] = 8'(next_rand() % 8); // Data region at 8000h
                mem[pc + 16'd1] = 8'h80;
                pc += 16'd2;
            end else if (operand_bytes(op) == 2'd2) begin
                // Forward jump into a short run of NOPs
                pad = int'(next_rand() % 4);
                target = pc + 16'd2 + 16'(next_rand() % (pad + 1));
                mem[pc] = target[7:0];
                mem[pc + 16'd1] = target[15:8];
                pc += 16'd2;
                repeat (pad) begin
                    mem[pc] = NOP;
                    pc++;
                end
            end else if (operand_bytes(op) == 2'd1) begin
                mem[pc] = 8'(next_rand());
                pc++;
            end
        end
        foreach (epilogue[i]) begin
            mem[pc] = epilogue[i];
            pc++;
        end
    endtask

    // ====================
    // Instruction model
    // ====================
    task automatic step_model();
        logic [DATA_WIDTH-1:0] lo, hi, src, res;
        logic [DATA_WIDTH:0]   wide;
        logic [ADDR_WIDTH-1:0] target;
        opcode_t               op;
        int                    n;
        op = opcode_t'(mem[model_pc]);
        n = operand_bytes(op);
        lo = mem[model_pc + 16'd1];
        hi = mem[model_pc + 16'd2];
        target = {hi, lo};
        for (int i = 0; i <= n; i++)
            push_access(model_pc + 16'(i), 1'b0, '0); // Opcode and operand fetches
        model_pc = model_pc + 16'(n + 1);
        src = (op == ADD_C || op == SUB_C) ? model_c : model_b;
        case (op)
            HLT:    model_halted = 1'b1;
            LDI_A:  model_a = lo;
            LDI_B:  model_b = lo;
            LDI_C:  model_c = lo;
            MOV_AB: model_b = model_a;
            MOV_BA: model_a = model_b;
            MOV_AC: model_c = model_a;
            MOV_CA: model_a = model_c;
            ADD_B, ADD_C: begin
                wide = {1'b0, model_a} + {1'b0, src};
                model_cy = wide[DATA_WIDTH];
                model_a = wide[DATA_WIDTH-1:0];
                model_z = (model_a == '0);
            end
            SUB_B, SUB_C, CMP_B: begin
                res = model_a - src;
                model_cy = (model_a < src); // Borrow
                model_z = (res == '0);
                if (op != CMP_B)
                    model_a = res;
            end
            INR_A, DCR_A: begin
                model_a = (op == INR_A) ? model_a + 8'd1 : model_a - 8'd1;
                model_z = (model_a == '0);
            end
            ANI, ORI, XRI: begin
                res = (op == ANI) ? (model_a & lo) : (op == ORI) ? (model_a | lo) : (model_a ^ lo);
                model_a = res;
                model_cy = 1'b0;
                model_z = (res == '0);
            end
            SEC: model_cy = 1'b1;
            CLC: model_cy = 1'b0;
            JMP: model_pc = target;
            JZ:  if (model_z) model_pc = target;
            JNZ: if (!model_z) model_pc = target;
            JC:  if (model_cy) model_pc = target;
            JNC: if (!model_cy) model_pc = target;
            LDA: begin
                push_access(target, 1'b0, '0);
                model_a = mem[target];
                model_z = (model_a == '0); // Loaded byte sets Z
            end
            STA: push_access(target, 1'b1, model_a);
            default: ;
        endcase
        if (op == LDI_A || op == LDI_B || op == LDI_C)
            model_z = (lo == '0);
    endtask

    // Compares a finished bus cycle with the model
    task automatic complete_access();
        logic [ADDR_WIDTH-1:0] adr;
        logic                  we;
        logic [DATA_WIDTH-1:0] dat;
        assert (!(model_halted && exp_adr.size() == 0)) else begin
            $display("Bus cycle at %0t after the program reached HLT", $time);
            report_failure();
        end
        if (exp_adr.size() == 0)
            step_model();
        adr = exp_adr.pop_front();
        we = exp_we.pop_front();
        dat = exp_dat.pop_front();
        assert (bus_out.stb) else report_mismatch("bus_out.stb", 16'd1, 16'(bus_out.stb));
        assert (bus_out.adr == adr) else report_mismatch("bus_out.adr", adr, bus_out.adr);
        assert (bus_out.we == we) else report_mismatch("bus_out.we", 16'(we), 16'(bus_out.we));
        if (we) begin
            assert (bus_out.dat_w == dat)
                else report_mismatch("bus_out.dat_w", 16'(dat), 16'(bus_out.dat_w));
            mem[adr] = dat;
        end
    endtask

    // ====================
    // Memory with random ack delay
    // ====================
    always @(posedge clk) begin
        if (STATIC_RESET) begin
            bus_in <= '0;
            wait_cnt = 0;
        end else if (bus_in.ack) begin
            complete_access(); // Handshake ends on this edge
            bus_in.ack <= 1'b0;
        end else if (bus_out.cyc) begin
            if (wait_cnt == 0) begin
                bus_in.ack   <= 1'b1;
                bus_in.dat_r <= mem[bus_out.adr];
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end else if (cpu_top_inst.wb_master_inst.start) begin
            // Request starts on this edge; delay 0 acks in its first cycle
            wait_cnt = int'(next_rand() % 4);
            if (wait_cnt == 0) begin
                bus_in.ack   <= 1'b1;
                bus_in.dat_r <= mem[cpu_top_inst.adr];
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    // Wishbone protocol checker
    always @(posedge clk) begin
        assert (cpu_top_inst.asserts_inst.fail_count == 0) else begin
            $display("Wishbone protocol assertion failed before %0t", $time);
            report_failure();
        end
    end

    initial begin
        int cycles;
        model_a = '0;
        model_b = '0;
        model_c = '0;
        model_z = 1'b0;
        model_cy = 1'b0;
        model_pc = RESET_VECTOR;
        model_halted = 1'b0;
        build_program();

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i > 0) begin
                assert (!bus_out.cyc) else report_mismatch("bus_out.cyc", 16'd0, 16'(bus_out.cyc));
                assert (!halted) else report_mismatch("halted", 16'd0, 16'(halted));
            end
        end
        STATIC_RESET <= 1'b0;

        cycles = 0;
        while (!halted && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        assert (halted) else begin
            $display("Timeout: halted did not rise within 20000 cycles");
            report_failure();
        end
        assert (model_halted && exp_adr.size() == 0) else begin
            $display("halted rose before the program reached HLT");
            report_failure();
        end

        // Core must stay quiet once halted
        repeat (50) begin
            @(posedge clk);
            assert (!bus_out.cyc) else report_mismatch("bus_out.cyc", 16'd0, 16'(bus_out.cyc));
            assert (halted) else report_mismatch("halted", 16'd1, 16'(halted));
        end

        if (cpu_top_inst.asserts_inst.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "Bound protocol assertions failed");
        end
    end

endmodule

/* sources.f */
src/cpu_pkg.sv
src/cpu_control.sv
src/register_file.sv
src/alu.sv
src/address_unit.sv
src/wb_master.sv
src/cpu_top.sv
testbench/tb_clock.sv
testbench/cpu_top_asserts.sv
testbench/cpu_tb.sv
